/* source/dma_pkg.sv */
`default_nettype none

package dma_pkg;

  localparam int DATA_W  = 64;
  localparam int ADDR_W  = 10;
  localparam int LEN_W   = 8;
  localparam int MAX_LEN = 64;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0]  len_t;

  // Requested length forced into the legal range 1 to MAX_LEN
  function automatic len_t clamp_len(len_t len);
    len_t res;
    res = len;
    if (len == '0)
      res = len_t'(1);
    else if (len > len_t'(MAX_LEN))
      res = len_t'(MAX_LEN);
    return res;
  endfunction

endpackage

`default_nettype wire

/* source/burst_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_ram
(
  input  wire logic           ddr_clk,
  input  wire logic           ram_en,
  input  wire logic           ram_we,
  input  wire dma_pkg::addr_t ram_addr,
  input  wire dma_pkg::data_t ram_wdata,
  output dma_pkg::data_t      ram_rdata
);

  import dma_pkg::*;

  data_t mem [0:(2**ADDR_W)-1];

  // Read data registered, one cycle after the request
  always_ff @(posedge ddr_clk)
  begin
    if (ram_en)
    begin
      if (ram_we)
        mem[ram_addr] <= ram_wdata;
      else
        ram_rdata <= mem[ram_addr];
    end
  end

endmodule

`default_nettype wire

/* source/mem_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter
(
  input  wire logic           ddr_clk,
  input  wire logic           rst_n,
  input  wire logic           wr_mem_req,
  input  wire dma_pkg::addr_t wr_mem_addr,
  input  wire dma_pkg::data_t wr_mem_data,
  output logic                wr_mem_gnt,
  input  wire logic           rd_mem_req,
  input  wire dma_pkg::addr_t rd_mem_addr,
  output logic                rd_mem_gnt,
  output dma_pkg::data_t      rd_mem_data,
  output logic                rd_mem_valid,
  output logic                ram_en,
  output logic                ram_we,
  output dma_pkg::addr_t      ram_addr,
  output dma_pkg::data_t      ram_wdata,
  input  wire dma_pkg::data_t ram_rdata
);

  // High when the read side wins the next contention
  logic rd_turn;

  assign wr_mem_gnt = wr_mem_req && (!rd_mem_req || !rd_turn);
  assign rd_mem_gnt = rd_mem_req && (!wr_mem_req || rd_turn);

  assign ram_en    = wr_mem_gnt || rd_mem_gnt;
  assign ram_we    = wr_mem_gnt;
  assign ram_addr  = wr_mem_gnt ? wr_mem_addr : rd_mem_addr;
  assign ram_wdata = wr_mem_data;

  // RAM output is valid the cycle after a read grant
  assign rd_mem_data = ram_rdata;

  always_ff @(posedge ddr_clk)
  begin
    if (!rst_n)
    begin
      rd_turn      <= 1'b0;
      rd_mem_valid <= 1'b0;
    end
    else
    begin
      if (wr_mem_gnt)
        rd_turn <= 1'b1;
      else if (rd_mem_gnt)
        rd_turn <= 1'b0;
      rd_mem_valid <= rd_mem_gnt;
    end
  end

endmodule

`default_nettype wire

/* source/write_dma.sv */
`timescale 1ns/1ps
`default_nettype none

module write_dma
(
  input  wire logic           ddr_clk,
  input  wire logic           rst_n,
  input  wire logic           write_req,
  input  wire dma_pkg::addr_t write_start_addr,
  input  wire dma_pkg::len_t  write_length,
  output logic                write_done,
  input  wire dma_pkg::data_t din,
  output logic                din_rdy,
  input  wire logic           din_en,
  input  wire logic           din_eop,
  output logic                wr_mem_req,
  output dma_pkg::addr_t      wr_mem_addr,
  output dma_pkg::data_t      wr_mem_data,
  input  wire logic           wr_mem_gnt
);

  import dma_pkg::*;

  logic busy;
  logic closing;
  logic start;
  logic beat_acc;
  logic last_beat;
  len_t len_q;
  len_t beat_cnt;

  // A new transfer only after the previous done has been released
  assign start     = write_req && !busy && !write_done;
  // Holding register empty and the final beat not yet taken
  assign din_rdy   = busy && !closing && !wr_mem_req;
  assign beat_acc  = din_en && din_rdy;
  assign last_beat = din_eop || (beat_cnt + 1'b1 == len_q);

  always_ff @(posedge ddr_clk)
  begin
    if (!rst_n)
    begin
      busy       <= 1'b0;
      closing    <= 1'b0;
      wr_mem_req <= 1'b0;
      write_done <= 1'b0;
    end
    else
    begin
      if (start)
      begin
        busy    <= 1'b1;
        closing <= 1'b0;
      end
      if (beat_acc)
      begin
        wr_mem_req <= 1'b1;
        if (last_beat)
          closing <= 1'b1;
      end
      else if (wr_mem_gnt)
      begin
        wr_mem_req <= 1'b0;
        if (closing)
        begin
          busy       <= 1'b0;
          write_done <= 1'b1;
        end
      end
      // Release done once the host drops its request
      if (write_done && !write_req)
        write_done <= 1'b0;
    end
  end

  // Address advances on each grant, so it always points at the held beat
  always_ff @(posedge ddr_clk)
  begin
    if (start)
    begin
      wr_mem_addr <= write_start_addr;
      len_q       <= clamp_len(write_length);
      beat_cnt    <= '0;
    end
    if (beat_acc)
    begin
      wr_mem_data <= din;
      beat_cnt    <= beat_cnt + 1'b1;
    end
    if (wr_mem_gnt)
      wr_mem_addr <= wr_mem_addr + 1'b1;
  end

endmodule

`default_nettype wire

/* source/read_dma.sv */
`timescale 1ns/1ps
`default_nettype none

module read_dma #(
  parameter int NUM_READERS = 4
)
(
  input  wire logic                             ddr_clk,
  input  wire logic                             rst_n,
  input  wire logic [NUM_READERS-1:0]           read_req,
  input  wire dma_pkg::addr_t [NUM_READERS-1:0] read_start_addr,
  input  wire dma_pkg::len_t  [NUM_READERS-1:0] read_length,
  output logic [NUM_READERS-1:0]                read_ack,
  output logic                                  rd_mem_req,
  output dma_pkg::addr_t                        rd_mem_addr,
  input  wire logic                             rd_mem_gnt,
  input  wire dma_pkg::data_t                   rd_mem_data,
  input  wire logic                             rd_mem_valid,
  output dma_pkg::data_t                        dout,
  output logic [NUM_READERS-1:0]                dout_en,
  output logic                                  dout_eop
);

  import dma_pkg::*;

  localparam int PTR_W = (NUM_READERS > 1) ? $clog2(NUM_READERS) : 1;

  logic [NUM_READERS-1:0] eligible;
  logic [NUM_READERS-1:0] owner_oh;
  logic [PTR_W-1:0]       rr_ptr;
  logic [PTR_W-1:0]       pick_idx;
  logic                   pick_valid;
  logic                   start;
  logic                   busy;
  len_t                   len_q;
  len_t                   issue_cnt;
  len_t                   ret_cnt;

  // Requesters already acked wait for their req to drop
  assign eligible = read_req & ~read_ack;

  always_comb
  begin
    int idx;
    pick_valid = 1'b0;
    pick_idx   = '0;
    for (int k = 0; k < NUM_READERS; k++)
    begin
      idx = int'(rr_ptr) + k;
      if (idx >= NUM_READERS)
        idx = idx - NUM_READERS;
      if (!pick_valid && eligible[idx])
      begin
        pick_valid = 1'b1;
        pick_idx   = idx[PTR_W-1:0];
      end
    end
  end

  assign start      = pick_valid && !busy;
  assign rd_mem_req = busy && (issue_cnt != len_q);

  always_ff @(posedge ddr_clk)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      rr_ptr   <= '0;
      read_ack <= '0;
      dout_en  <= '0;
      dout_eop <= 1'b0;
    end
    else
    begin
      if (start)
      begin
        busy   <= 1'b1;
        rr_ptr <= (int'(pick_idx) == NUM_READERS - 1) ? '0 : pick_idx + 1'b1;
      end
      // Burst finished once its last beat has left the output stage
      if (dout_eop)
        busy <= 1'b0;
      read_ack <= (read_ack & read_req) | (dout_eop ? dout_en : '0);
      dout_en  <= rd_mem_valid ? owner_oh : '0;
      dout_eop <= rd_mem_valid && (ret_cnt + 1'b1 == len_q);
    end
  end

  always_ff @(posedge ddr_clk)
  begin
    if (start)
    begin
      rd_mem_addr        <= read_start_addr[pick_idx];
      len_q              <= clamp_len(read_length[pick_idx]);
      issue_cnt          <= '0;
      ret_cnt            <= '0;
      owner_oh           <= '0;
      owner_oh[pick_idx] <= 1'b1;
    end
    if (rd_mem_gnt)
    begin
      rd_mem_addr <= rd_mem_addr + 1'b1;
      issue_cnt   <= issue_cnt + 1'b1;
    end
    if (rd_mem_valid)
    begin
      dout    <= rd_mem_data;
      ret_cnt <= ret_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/top_dma_ddr.sv */
`timescale 1ns/1ps
`default_nettype none

module top_dma_ddr #(
  parameter int NUM_READERS = 4
)
(
  input  wire logic                             ddr_clk,
  input  wire logic                             rst_n,
  input  wire logic                             write_req,
  input  wire dma_pkg::addr_t                   write_start_addr,
  input  wire dma_pkg::len_t                    write_length,
  output logic                                  write_done,
  input  wire dma_pkg::data_t                   din,
  output logic                                  din_rdy,
  input  wire logic                             din_en,
  input  wire logic                             din_eop,
  output dma_pkg::data_t                        dout,
  output logic [NUM_READERS-1:0]                dout_en,
  output logic                                  dout_eop,
  input  wire logic [NUM_READERS-1:0]           read_req,
  input  wire dma_pkg::addr_t [NUM_READERS-1:0] read_start_addr,
  input  wire dma_pkg::len_t  [NUM_READERS-1:0] read_length,
  output logic [NUM_READERS-1:0]                read_ack
);

  import dma_pkg::*;

  logic  wr_mem_req;
  logic  wr_mem_gnt;
  addr_t wr_mem_addr;
  data_t wr_mem_data;
  logic  rd_mem_req;
  logic  rd_mem_gnt;
  addr_t rd_mem_addr;
  data_t rd_mem_data;
  logic  rd_mem_valid;
  logic  ram_en;
  logic  ram_we;
  addr_t ram_addr;
  data_t ram_wdata;
  data_t ram_rdata;

  write_dma u_write_dma (
    .ddr_clk          (ddr_clk),
    .rst_n            (rst_n),
    .write_req        (write_req),
    .write_start_addr (write_start_addr),
    .write_length     (write_length),
    .write_done       (write_done),
    .din              (din),
    .din_rdy          (din_rdy),
    .din_en           (din_en),
    .din_eop          (din_eop),
    .wr_mem_req       (wr_mem_req),
    .wr_mem_addr      (wr_mem_addr),
    .wr_mem_data      (wr_mem_data),
    .wr_mem_gnt       (wr_mem_gnt)
  );

  read_dma #(
    .NUM_READERS (NUM_READERS)
  ) u_read_dma (
    .ddr_clk         (ddr_clk),
    .rst_n           (rst_n),
    .read_req        (read_req),
    .read_start_addr (read_start_addr),
    .read_length     (read_length),
    .read_ack        (read_ack),
    .rd_mem_req      (rd_mem_req),
    .rd_mem_addr     (rd_mem_addr),
    .rd_mem_gnt      (rd_mem_gnt),
    .rd_mem_data     (rd_mem_data),
    .rd_mem_valid    (rd_mem_valid),
    .dout            (dout),
    .dout_en         (dout_en),
    .dout_eop        (dout_eop)
  );

  mem_port_arbiter u_mem_port_arbiter (
    .ddr_clk      (ddr_clk),
    .rst_n        (rst_n),
    .wr_mem_req   (wr_mem_req),
    .wr_mem_addr  (wr_mem_addr),
    .wr_mem_data  (wr_mem_data),
    .wr_mem_gnt   (wr_mem_gnt),
    .rd_mem_req   (rd_mem_req),
    .rd_mem_addr  (rd_mem_addr),
    .rd_mem_gnt   (rd_mem_gnt),
    .rd_mem_data  (rd_mem_data),
    .rd_mem_valid (rd_mem_valid),
    .ram_en       (ram_en),
    .ram_we       (ram_we),
    .ram_addr     (ram_addr),
    .ram_wdata    (ram_wdata),
    .ram_rdata    (ram_rdata)
  );

  burst_ram u_burst_ram (
    .ddr_clk   (ddr_clk),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

endmodule

`default_nettype wire

/* testbench/dma_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_checker #(
  parameter int NUM_READERS = 4
)
(
  input  wire logic                             ddr_clk,
  input  wire logic                             rst_n,
  input  wire logic                             write_req,
  input  wire dma_pkg::addr_t                   write_start_addr,
  input  wire dma_pkg::len_t                    write_length,
  input  wire logic                             write_done,
  input  wire dma_pkg::data_t                   din,
  input  wire logic                             din_rdy,
  input  wire logic                             din_en,
  input  wire logic                             din_eop,
  input  wire dma_pkg::data_t                   dout,
  input  wire logic [NUM_READERS-1:0]           dout_en,
  input  wire logic                             dout_eop,
  input  wire logic [NUM_READERS-1:0]           read_req,
  input  wire dma_pkg::addr_t [NUM_READERS-1:0] read_start_addr,
  input  wire dma_pkg::len_t  [NUM_READERS-1:0] read_length,
  input  wire logic [NUM_READERS-1:0]           read_ack,
  output int                                    error_count
);

  import dma_pkg::*;

  data_t                  shadow  [0:(2**ADDR_W)-1];
  logic                   written [0:(2**ADDR_W)-1];
  logic                   active;
  logic                   wr_req_q;
  logic                   wr_done_q;
  logic                   wr_last;
  addr_t                  wr_addr;
  int                     wr_len;
  int                     wr_cnt;
  logic [NUM_READERS-1:0] rd_req_q;
  logic [NUM_READERS-1:0] rd_ack_q;
  logic [NUM_READERS-1:0] rd_last;
  logic [NUM_READERS-1:0] eop_q;
  logic [NUM_READERS-1:0] owner_q;
  addr_t                  rd_addr [NUM_READERS];
  int                     rd_len  [NUM_READERS];
  int                     rd_cnt  [NUM_READERS];

  task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] got);
    error_count++;
    $display("Error at time %0t: %s expected %h, got %h", $time, name, exp, got);
  endtask

  task automatic rule_error(input string msg);
    error_count++;
    $display("Failure at time %0t: %s", $time, msg);
  endtask

  initial
  begin
    error_count = 0;
    for (int k = 0; k < 2**ADDR_W; k++)
      written[k] = 1'b0;
  end

  // Sampled on the rising edge, so all values are the settled ones of the cycle
  always @(posedge ddr_clk)
  begin
    int                     own;
    addr_t                  a;
    logic                   exp_eop;
    logic [NUM_READERS-1:0] exp_en;
    if (!rst_n)
    begin
      active    = 1'b0;
      wr_req_q  = 1'b0;
      wr_done_q = 1'b0;
      wr_last   = 1'b0;
      rd_req_q  = '0;
      rd_ack_q  = '0;
      rd_last   = '0;
      eop_q     = '0;
      owner_q   = '0;
    end
    else
    begin
      if (!active && (din_rdy || write_done || read_ack != '0 || dout_en != '0 || dout_eop))
        rule_error("outputs active before any request");
      if (write_req || read_req != '0)
        active = 1'b1;

      // Write done handshake
      if (write_done && !wr_done_q && !wr_last)
        rule_error("write_done rose before the final beat");
      if (wr_done_q && wr_req_q && !write_done)
        value_error("write_done", 1, 0);
      if (wr_done_q && !wr_req_q && write_done)
        value_error("write_done", 0, 1);
      if (write_req && !wr_req_q)
      begin
        wr_addr = write_start_addr;
        wr_len  = int'(write_length);
        wr_cnt  = 0;
        wr_last = 1'b0;
      end
      if (din_en && din_rdy)
      begin
        if (wr_last)
          rule_error("beat accepted after the final beat");
        a          = wr_addr + addr_t'(wr_cnt);
        shadow[a]  = din;
        written[a] = 1'b1;
        wr_cnt++;
        if (din_eop || wr_cnt == wr_len)
          wr_last = 1'b1;
      end

      for (int i = 0; i < NUM_READERS; i++)
      begin
        if (read_ack[i] && !rd_ack_q[i] && !rd_last[i])
          rule_error($sformatf("read_ack[%0d] rose before the last beat", i));
        if ((eop_q[i] || (rd_ack_q[i] && rd_req_q[i])) && !read_ack[i])
          value_error($sformatf("read_ack[%0d]", i), 1, 0);
        if (rd_ack_q[i] && !rd_req_q[i] && read_ack[i])
          value_error($sformatf("read_ack[%0d]", i), 0, 1);
        if (read_req[i] && !rd_req_q[i])
        begin
          rd_addr[i] = read_start_addr[i];
          rd_len[i]  = int'(read_length[i]);
          rd_cnt[i]  = 0;
          rd_last[i] = 1'b0;
        end
      end

      if (dout_en != '0)
      begin
        own = 0;
        for (int i = 0; i < NUM_READERS; i++)
          if (dout_en[i])
            own = i;
        // An open burst keeps its owner until its eop
        exp_en      = '0;
        exp_en[own] = 1'b1;
        if (owner_q != '0)
          exp_en = owner_q;
        if (dout_en != exp_en)
          value_error("dout_en", exp_en, dout_en);
        else if (rd_cnt[own] >= rd_len[own])
          rule_error($sformatf("extra beat for requester %0d", own));
        else
        begin
          a = rd_addr[own] + addr_t'(rd_cnt[own]);
          if (!written[a])
            rule_error($sformatf("read of unwritten address %0h", a));
          else if (dout !== shadow[a])
            value_error("dout", shadow[a], dout);
          exp_eop = (rd_cnt[own] + 1 == rd_len[own]);
          if (dout_eop !== exp_eop)
            value_error("dout_eop", exp_eop, dout_eop);
          rd_cnt[own]++;
          if (rd_cnt[own] == rd_len[own])
            rd_last[own] = 1'b1;
          owner_q = dout_eop ? '0 : dout_en;
        end
      end
      else if (dout_eop)
        value_error("dout_eop", 0, 1);

      eop_q     = dout_eop ? dout_en : '0;
      wr_req_q  = write_req;
      wr_done_q = write_done;
      rd_req_q  = read_req;
      rd_ack_q  = read_ack;
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_top_dma_ddr.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top_dma_ddr;

  import dma_pkg::*;

  localparam int NUM_READERS = 4;
  localparam int WAIT_LIMIT  = 2000;
  localparam int NUM_ROWS    = 14;

  localparam int OP_WRITE = 0;
  localparam int OP_READ  = 1;
  localparam int OP_READS = 2;
  localparam int OP_MIXED = 3;

  logic                    ddr_clk;
  logic                    rst_n;
  logic                    write_req;
  addr_t                   write_start_addr;
  len_t                    write_length;
  logic                    write_done;
  data_t                   din;
  logic                    din_rdy;
  logic                    din_en;
  logic                    din_eop;
  data_t                   dout;
  logic [NUM_READERS-1:0]  dout_en;
  logic                    dout_eop;
  logic [NUM_READERS-1:0]  read_req;
  addr_t [NUM_READERS-1:0] read_start_addr;
  len_t  [NUM_READERS-1:0] read_length;
  logic [NUM_READERS-1:0]  read_ack;
  integer                  seed;
  int                      timeouts;
  int                      check_errors;
  int                      row_cnt;
  int                      tbl_op   [NUM_ROWS];
  logic [NUM_READERS-1:0]  tbl_mask [NUM_ROWS];
  addr_t                   tbl_addr [NUM_ROWS];
  len_t                    tbl_len  [NUM_ROWS];
  int                      tbl_eop  [NUM_ROWS];
  addr_t                   tbl_aux  [NUM_ROWS];

  top_dma_ddr #(
    .NUM_READERS (NUM_READERS)
  ) u_top_dma_ddr (
    .*
  );

  dma_checker #(
    .NUM_READERS (NUM_READERS)
  ) u_dma_checker (
    .error_count (check_errors),
    .*
  );

  initial
  begin
    ddr_clk = 1'b0;
    forever
      #5 ddr_clk = ~ddr_clk;
  end

  task automatic timeout_fail(input string msg);
    timeouts++;
    $display("Timeout at time %0t: %s", $time, msg);
  endtask

  // eop_at counts beats from 1 and zero means no early eop
  task automatic add_row(input int op, input logic [NUM_READERS-1:0] mask, input addr_t a,
                         input len_t l, input int eop_at, input addr_t aux);
    tbl_op[row_cnt]   = op;
    tbl_mask[row_cnt] = mask;
    tbl_addr[row_cnt] = a;
    tbl_len[row_cnt]  = l;
    tbl_eop[row_cnt]  = eop_at;
    tbl_aux[row_cnt]  = aux;
    row_cnt++;
  endtask

  task automatic run_write(input addr_t a, input len_t l, input int eop_at);
    int n;
    int t;
    n = (eop_at != 0) ? eop_at : int'(l);
    @(negedge ddr_clk);
    write_req        = 1'b1;
    write_start_addr = a;
    write_length     = l;
    for (int b = 0; b < n; b++)
    begin
      t = 0;
      while (!din_rdy && t < WAIT_LIMIT)
      begin
        @(negedge ddr_clk);
        t++;
      end
      if (!din_rdy)
        timeout_fail("din_rdy stayed low");
      din     = {$random(seed), $random(seed)};
      din_en  = 1'b1;
      din_eop = (eop_at != 0) && (b == n - 1);
      @(negedge ddr_clk);
      din_en  = 1'b0;
      din_eop = 1'b0;
    end
    // A spare beat stays offered after the final one and must be refused
    din_en = 1'b1;
    t = 0;
    while (!write_done && t < WAIT_LIMIT)
    begin
      @(negedge ddr_clk);
      t++;
    end
    if (!write_done)
      timeout_fail("write_done did not rise");
    // Request held one more cycle so done must stay high
    @(negedge ddr_clk);
    write_req = 1'b0;
    din_en    = 1'b0;
    t = 0;
    while (write_done && t < WAIT_LIMIT)
    begin
      @(negedge ddr_clk);
      t++;
    end
    if (write_done)
      timeout_fail("write_done did not fall after write_req dropped");
  endtask

  // The k-th requester of the mask reads from a + k*l
  // Each req is held one cycle past its ack before it drops
  task automatic run_reads(input logic [NUM_READERS-1:0] mask, input addr_t a, input len_t l);
    int                     t;
    int                     rank;
    logic [NUM_READERS-1:0] acked;
    logic [NUM_READERS-1:0] seen;
    @(negedge ddr_clk);
    rank = 0;
    for (int i = 0; i < NUM_READERS; i++)
    begin
      if (mask[i])
      begin
        read_start_addr[i] = addr_t'(int'(a) + rank * int'(l));
        read_length[i]     = l;
        read_req[i]        = 1'b1;
        rank++;
      end
    end
    acked = '0;
    seen  = '0;
    t = 0;
    while (acked != mask && t < WAIT_LIMIT)
    begin
      @(negedge ddr_clk);
      t++;
      for (int i = 0; i < NUM_READERS; i++)
      begin
        if (mask[i] && read_req[i] && read_ack[i])
        begin
          if (seen[i])
          begin
            read_req[i] = 1'b0;
            acked[i]    = 1'b1;
          end
          seen[i] = 1'b1;
        end
      end
    end
    if (acked != mask)
    begin
      timeout_fail("read_ack did not rise for every requester");
      read_req = read_req & ~mask;
    end
    t = 0;
    while ((read_ack & mask) != '0 && t < WAIT_LIMIT)
    begin
      @(negedge ddr_clk);
      t++;
    end
    if ((read_ack & mask) != '0)
      timeout_fail("read_ack did not fall after read_req dropped");
  endtask

  initial
  begin
    seed             = 67801;
    timeouts         = 0;
    row_cnt          = 0;
    rst_n            = 1'b0;
    write_req        = 1'b0;
    write_start_addr = '0;
    write_length     = '0;
    din              = '0;
    din_en           = 1'b0;
    din_eop          = 1'b0;
    read_req         = '0;
    read_start_addr  = '0;
    read_length      = '0;

    add_row(OP_WRITE, 4'b0000, 10'h000, 8'd16, 0, 10'h000);
    add_row(OP_READ,  4'b0001, 10'h000, 8'd16, 0, 10'h000);
    add_row(OP_WRITE, 4'b0000, 10'h040, 8'd64, 0, 10'h000);
    add_row(OP_READ,  4'b0010, 10'h040, 8'd64, 0, 10'h000);
    add_row(OP_WRITE, 4'b0000, 10'h100, 8'd32, 0, 10'h000);
    add_row(OP_READS, 4'b1111, 10'h100, 8'd8,  0, 10'h000);
    // Early eop on beat 5 leaves the old words 5 to 15 in place
    add_row(OP_WRITE, 4'b0000, 10'h000, 8'd16, 5, 10'h000);
    add_row(OP_READ,  4'b0100, 10'h000, 8'd16, 0, 10'h000);
    add_row(OP_MIXED, 4'b1001, 10'h040, 8'd16, 0, 10'h300);
    add_row(OP_READ,  4'b1000, 10'h300, 8'd16, 0, 10'h000);
    // Wraps around the top of the memory
    add_row(OP_WRITE, 4'b0000, 10'h3f8, 8'd16, 0, 10'h000);
    add_row(OP_READ,  4'b0010, 10'h3f8, 8'd16, 0, 10'h000);
    add_row(OP_READ,  4'b0001, 10'h3ff, 8'd1,  0, 10'h000);
    add_row(OP_READS, 4'b0110, 10'h040, 8'd16, 0, 10'h000);

    repeat (8) @(negedge ddr_clk);
    rst_n = 1'b1;
    // Quiet window for the idle checks after reset
    repeat (5) @(negedge ddr_clk);

    for (int r = 0; r < row_cnt; r++)
    begin
      case (tbl_op[r])
        OP_WRITE:
          run_write(tbl_addr[r], tbl_len[r], tbl_eop[r]);
        OP_MIXED:
          fork
            run_reads(tbl_mask[r], tbl_addr[r], tbl_len[r]);
            run_write(tbl_aux[r], tbl_len[r], 0);
          join
        default:
          run_reads(tbl_mask[r], tbl_addr[r], tbl_len[r]);
      endcase
    end

    repeat (5) @(negedge ddr_clk);
    $display("Summary: %0d checker errors, %0d timeouts", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* top_dma_ddr.f */
source/dma_pkg.sv
source/burst_ram.sv
source/mem_port_arbiter.sv
source/write_dma.sv
source/read_dma.sv
source/top_dma_ddr.sv
testbench/dma_checker.sv
testbench/tb_top_dma_ddr.sv

/* Bender.yml */
package:
  name: top_dma_ddr

sources:
  - files:
      - source/dma_pkg.sv
      - source/burst_ram.sv
      - source/mem_port_arbiter.sv
      - source/write_dma.sv
      - source/read_dma.sv
      - source/top_dma_ddr.sv
  - target: test
    files:
      - testbench/dma_checker.sv
      - testbench/tb_top_dma_ddr.sv
